// File: Bender.yml
package:
  name: hififo_pcie

sources:
  - include_dirs:
      - src
    files:
      - src/pcie_tlp_pkg.sv
      - src/hififo_pkg.sv
      - src/pcie_rx.sv
      - src/pcie_pio_regs.sv
      - src/hififo_tpc_fifo.sv
      - src/pcie_tx.sv
      - src/hififo_pcie.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verif/hififo_pcie_tb.sv

// File: build.f
+incdir+src
src/pcie_tlp_pkg.sv
src/hififo_pkg.sv
src/pcie_rx.sv
src/pcie_pio_regs.sv
src/hififo_tpc_fifo.sv
src/pcie_tx.sv
src/hififo_pcie.sv
verif/hififo_pcie_tb.sv

// File: src/hififo_pcie.sv
module hififo_pcie
   import pcie_tlp_pkg::*;
   import hififo_pkg::*;
(
   input  logic       clock,
   input  logic       rst,
   input  pcie_id_t   pcie_id,
   input  logic       rx_tvalid,
   input  logic       rx_tlast,
   input  tlp_beat_t  rx_tdata,
   input  logic       tx_tready,
   output logic       tx_tvalid,
   output tlp_beat_t  tx_tdata,
   output logic       tx_tlast,
   output logic       tx_1dw,
   output logic       interrupt,
   input  logic       fifo_write,
   input  data_word_t fifo_data,
   output logic       fifo_ready
);

   // PIO requests from the receive parser
   logic       write_valid;
   logic       read_valid;
   pio_addr_t  address;
   data_word_t data;
   pcie_id_t   req_id;
   tlp_tag_t   req_tag;

   // register block outputs
   dma_addr_t  dma_base;
   logic       base_load;
   logic       dma_enable;
   logic       rc_done;
   data_word_t rc_data;
   pcie_id_t   rc_req_id;
   tlp_tag_t   rc_tag;
   logic [6:0] rc_addr_low;

   // buffer to transmit
   logic       wr_valid;
   logic       wr_ready;
   dma_addr_t  wr_addr;
   data_word_t burst_data;
   logic       burst_read;
   logic       burst_done;

   pcie_rx rx
   (
      .clock       (clock),
      .rst         (rst),
      .rx_tvalid   (rx_tvalid),
      .rx_tlast    (rx_tlast),
      .rx_tdata    (rx_tdata),
      .write_valid (write_valid),
      .read_valid  (read_valid),
      .address     (address),
      .data        (data),
      .req_id      (req_id),
      .req_tag     (req_tag)
   );

   pcie_pio_regs regs
   (
      .clock       (clock),
      .rst         (rst),
      .write_valid (write_valid),
      .read_valid  (read_valid),
      .address     (address),
      .data        (data),
      .req_id      (req_id),
      .req_tag     (req_tag),
      .burst_done  (burst_done),
      .interrupt   (interrupt),
      .dma_base    (dma_base),
      .base_load   (base_load),
      .dma_enable  (dma_enable),
      .rc_done     (rc_done),
      .rc_data     (rc_data),
      .rc_req_id   (rc_req_id),
      .rc_tag      (rc_tag),
      .rc_addr_low (rc_addr_low)
   );

   hififo_tpc_fifo tpc_fifo
   (
      .clock      (clock),
      .rst        (rst),
      .fifo_write (fifo_write),
      .fifo_data  (fifo_data),
      .dma_base   (dma_base),
      .base_load  (base_load),
      .dma_enable (dma_enable),
      .wr_ready   (wr_ready),
      .burst_read (burst_read),
      .fifo_ready (fifo_ready),
      .wr_valid   (wr_valid),
      .wr_addr    (wr_addr),
      .burst_data (burst_data),
      .burst_done (burst_done)
   );

   pcie_tx tx
   (
      .clock       (clock),
      .rst         (rst),
      .pcie_id     (pcie_id),
      .rc_done     (rc_done),
      .rc_data     (rc_data),
      .rc_req_id   (rc_req_id),
      .rc_tag      (rc_tag),
      .rc_addr_low (rc_addr_low),
      .wr_valid    (wr_valid),
      .wr_addr     (wr_addr),
      .burst_data  (burst_data),
      .tx_tready   (tx_tready),
      .wr_ready    (wr_ready),
      .burst_read  (burst_read),
      .tx_tvalid   (tx_tvalid),
      .tx_tdata    (tx_tdata),
      .tx_tlast    (tx_tlast),
      .tx_1dw      (tx_1dw)
   );

endmodule

// File: src/hififo_pkg.sv
`include "hififo_settings.svh"

package hififo_pkg;

   typedef logic [63:0] data_word_t;

   typedef logic [`HIFIFO_PIO_AW-1:0] pio_addr_t;

   // host byte address
   typedef logic [63:0] dma_addr_t;

   // one extra bit so that a full buffer is representable
   typedef logic [`HIFIFO_DEPTH_LOG2:0] fifo_count_t;

   typedef enum logic [1:0]
   {
      RX_IDLE,
      RX_ADDR,
      RX_HIGH,
      RX_SKIP
   } rx_state_e;

   typedef enum logic [2:0]
   {
      TX_IDLE,
      TX_CPL_HDR,
      TX_CPL_DATA,
      TX_WR_HDR,
      TX_WR_DATA
   } tx_state_e;

endpackage

// File: src/hififo_settings.svh
`ifndef HIFIFO_SETTINGS_SVH
`define HIFIFO_SETTINGS_SVH

// to-PC buffer depth in 64-bit words, as log2
`define HIFIFO_DEPTH_LOG2 6

// words carried by one memory-write TLP
`define HIFIFO_BURST_WORDS 16

// host ring size in bytes, a whole number of bursts
`define HIFIFO_RING_BYTES 1024

// PIO word-address width, taken from DW2 bits 15:3
`define HIFIFO_PIO_AW 13

// returned on a read of PIO address 0
`define HIFIFO_VERSION 257

`endif

// File: src/hififo_tpc_fifo.sv
`include "hififo_settings.svh"

module hififo_tpc_fifo
   import hififo_pkg::*;
(
   input  logic       clock,
   input  logic       rst,
   input  logic       fifo_write,
   input  data_word_t fifo_data,
   input  dma_addr_t  dma_base,
   input  logic       base_load,
   input  logic       dma_enable,
   input  logic       wr_ready,
   input  logic       burst_read,
   output logic       fifo_ready,
   output logic       wr_valid,
   output dma_addr_t  wr_addr,
   output data_word_t burst_data,
   output logic       burst_done
);

   localparam int PW = `HIFIFO_DEPTH_LOG2;
   localparam int BW = `HIFIFO_BURST_WORDS;
   localparam int CW = $clog2(BW);
   localparam fifo_count_t DEPTH = fifo_count_t'(1 << PW);
   localparam dma_addr_t BURST_BYTES = dma_addr_t'(BW * 8);
   localparam dma_addr_t RING_BYTES = dma_addr_t'(`HIFIFO_RING_BYTES);

   data_word_t    mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   fifo_count_t   count;
   logic [CW-1:0] pop_cnt;
   logic          in_burst;
   logic          push;
   dma_addr_t     ring_offset;

   assign fifo_ready = count != DEPTH;
   assign push       = fifo_write && fifo_ready;
   assign burst_data = mem[rd_ptr];
   assign burst_done = burst_read && pop_cnt == CW'(BW - 1);

   // a burst is offered once, and not again until its last word is gone
   assign wr_valid = dma_enable && !in_burst && count >= fifo_count_t'(BW);
   assign wr_addr  = dma_base + ring_offset;

   always_ff @(posedge clock)
   begin
      if (push)
         mem[wr_ptr] <= fifo_data;
   end

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         pop_cnt     <= '0;
         in_burst    <= 1'b0;
         ring_offset <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (burst_read)
         begin
            rd_ptr  <= rd_ptr + 1'b1;
            pop_cnt <= burst_done ? '0 : pop_cnt + 1'b1;
         end
         case ({push, burst_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (wr_ready)
            in_burst <= 1'b1;
         else if (burst_done)
            in_burst <= 1'b0;
         // step through the host ring, base write starts over
         if (base_load)
            ring_offset <= '0;
         else if (burst_done)
            ring_offset <= (ring_offset == RING_BYTES - BURST_BYTES) ?
                           '0 : ring_offset + BURST_BYTES;
      end
   end

   a_no_pop_empty: assert property (@(posedge clock) disable iff (rst)
      burst_read |-> count != '0);

   a_no_push_full: assert property (@(posedge clock) disable iff (rst)
      fifo_write |-> fifo_ready);

endmodule

// File: src/pcie_pio_regs.sv
`include "hififo_settings.svh"

module pcie_pio_regs
   import pcie_tlp_pkg::*;
   import hififo_pkg::*;
(
   input  logic       clock,
   input  logic       rst,
   input  logic       write_valid,
   input  logic       read_valid,
   input  pio_addr_t  address,
   input  data_word_t data,
   input  pcie_id_t   req_id,
   input  tlp_tag_t   req_tag,
   input  logic       burst_done,
   output logic       interrupt,
   output dma_addr_t  dma_base,
   output logic       base_load,
   output logic       dma_enable,
   output logic       rc_done,
   output data_word_t rc_data,
   output pcie_id_t   rc_req_id,
   output tlp_tag_t   rc_tag,
   output logic [6:0] rc_addr_low
);

   // bursts handed to the host since reset
   data_word_t burst_count;

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         interrupt   <= 1'b0;
         dma_enable  <= 1'b0;
         base_load   <= 1'b0;
         rc_done     <= 1'b0;
         burst_count <= '0;
      end
      else
      begin
         base_load <= write_valid && address == pio_addr_t'(1);
         rc_done   <= read_valid;
         if (burst_done)
            burst_count <= burst_count + 1'b1;
         if (write_valid && address == pio_addr_t'(0))
            interrupt <= data[0];
         if (write_valid && address == pio_addr_t'(2))
            dma_enable <= data[0];
      end
   end

   always_ff @(posedge clock)
   begin
      if (write_valid && address == pio_addr_t'(1))
         dma_base <= data;
      if (read_valid)
      begin
         case (address)
            pio_addr_t'(0): rc_data <= data_word_t'(`HIFIFO_VERSION);
            pio_addr_t'(1): rc_data <= dma_base;
            pio_addr_t'(3): rc_data <= burst_count;
            default:        rc_data <= '0;
         endcase
         rc_req_id   <= req_id;
         rc_tag      <= req_tag;
         // byte address bits 6:0 of the request
         rc_addr_low <= {address[3:0], 3'b000};
      end
   end

endmodule

// File: src/pcie_rx.sv
module pcie_rx
   import pcie_tlp_pkg::*;
   import hififo_pkg::*;
(
   input  logic       clock,
   input  logic       rst,
   input  logic       rx_tvalid,
   input  logic       rx_tlast,
   input  tlp_beat_t  rx_tdata,
   output logic       write_valid,
   output logic       read_valid,
   output pio_addr_t  address,
   output data_word_t data,
   output pcie_id_t   req_id,
   output tlp_tag_t   req_tag
);

   rx_state_e  state;
   logic       is_read;
   logic [6:0] fmt_type;
   tlp_len_t   length;

   // header fields of beat 0
   assign fmt_type = rx_tdata[30:24];
   assign length   = rx_tdata[9:0];

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         state       <= RX_IDLE;
         is_read     <= 1'b0;
         write_valid <= 1'b0;
         read_valid  <= 1'b0;
      end
      else
      begin
         write_valid <= 1'b0;
         read_valid  <= 1'b0;
         if (rx_tvalid)
         begin
            case (state)
               RX_IDLE:
               begin
                  // a single-beat TLP is never one of ours
                  if (!rx_tlast)
                  begin
                     if (fmt_type == MWR32 && length == tlp_len_t'(2))
                     begin
                        state   <= RX_ADDR;
                        is_read <= 1'b0;
                     end
                     else if (fmt_type == MRD32 && length == tlp_len_t'(2))
                     begin
                        state   <= RX_ADDR;
                        is_read <= 1'b1;
                     end
                     else
                        state <= RX_SKIP;
                  end
               end
               RX_ADDR:
               begin
                  if (is_read)
                  begin
                     read_valid <= rx_tlast;
                     state      <= rx_tlast ? RX_IDLE : RX_SKIP;
                  end
                  else
                     state <= rx_tlast ? RX_IDLE : RX_HIGH;
               end
               RX_HIGH:
               begin
                  write_valid <= rx_tlast;
                  state       <= rx_tlast ? RX_IDLE : RX_SKIP;
               end
               default:
               begin
                  if (rx_tlast)
                     state <= RX_IDLE;
               end
            endcase
         end
      end
   end

   // payload capture, held until the next TLP overwrites it
   always_ff @(posedge clock)
   begin
      if (rx_tvalid && state == RX_IDLE)
      begin
         req_id  <= rx_tdata[63:48];
         req_tag <= rx_tdata[47:40];
      end
      if (rx_tvalid && state == RX_ADDR)
      begin
         address    <= rx_tdata[3 +: $bits(pio_addr_t)];
         data[31:0] <= rx_tdata[63:32];
      end
      if (rx_tvalid && state == RX_HIGH)
         data[63:32] <= rx_tdata[31:0];
   end

   a_one_strobe: assert property (@(posedge clock) disable iff (rst)
      !(write_valid && read_valid));

endmodule

// File: src/pcie_tlp_pkg.sv
package pcie_tlp_pkg;

   // one TLP double word
   typedef logic [31:0] tlp_dw_t;

   // one 64-bit stream beat, lower DW in bits 31:0
   typedef logic [63:0] tlp_beat_t;

   // bus/device/function
   typedef logic [15:0] pcie_id_t;

   typedef logic [7:0] tlp_tag_t;

   // payload length in DWs
   typedef logic [9:0] tlp_len_t;

   // fmt/type field as found in DW0 bits 30:24
   typedef enum logic [6:0]
   {
      MRD32 = 7'h00,
      MWR32 = 7'h40,
      MWR64 = 7'h60,
      CPLD  = 7'h4A
   } tlp_kind_e;

endpackage

// File: src/pcie_tx.sv
`include "hififo_settings.svh"

module pcie_tx
   import pcie_tlp_pkg::*;
   import hififo_pkg::*;
(
   input  logic       clock,
   input  logic       rst,
   input  pcie_id_t   pcie_id,
   input  logic       rc_done,
   input  data_word_t rc_data,
   input  pcie_id_t   rc_req_id,
   input  tlp_tag_t   rc_tag,
   input  logic [6:0] rc_addr_low,
   input  logic       wr_valid,
   input  dma_addr_t  wr_addr,
   input  data_word_t burst_data,
   input  logic       tx_tready,
   output logic       wr_ready,
   output logic       burst_read,
   output logic       tx_tvalid,
   output tlp_beat_t  tx_tdata,
   output logic       tx_tlast,
   output logic       tx_1dw
);

   localparam int BW = `HIFIFO_BURST_WORDS;
   localparam int CW = $clog2(BW);

   tx_state_e     state;
   logic [CW-1:0] word_cnt;
   logic          cpl_pending;
   dma_addr_t     wr_addr_q;
   tlp_dw_t       cpl_dw0;
   tlp_dw_t       cpl_dw1;
   tlp_dw_t       cpl_dw2;
   tlp_dw_t       wr_dw0;
   tlp_dw_t       wr_dw1;

   // completion with 2 DWs of data, byte count 8
   assign cpl_dw0 = {1'b0, CPLD, 14'b0, tlp_len_t'(2)};
   assign cpl_dw1 = {pcie_id, 4'b0, 12'd8};
   assign cpl_dw2 = {rc_req_id, rc_tag, 1'b0, rc_addr_low};

   // 64-bit address write, all bytes enabled
   assign wr_dw0 = {1'b0, MWR64, 14'b0, tlp_len_t'(2 * BW)};
   assign wr_dw1 = {pcie_id, 8'h00, 4'hF, 4'hF};

   // completions go first
   assign wr_ready   = state == TX_IDLE && !cpl_pending && wr_valid;
   assign burst_read = state == TX_WR_DATA && tx_tready;
   assign tx_tvalid  = state != TX_IDLE;

   always_comb
   begin
      tx_tdata = '0;
      tx_tlast = 1'b0;
      tx_1dw   = 1'b0;
      case (state)
         TX_CPL_HDR:  tx_tdata = {cpl_dw1, cpl_dw0};
         TX_CPL_DATA:
         begin
            if (word_cnt == '0)
               tx_tdata = {rc_data[31:0], cpl_dw2};
            else
            begin
               // high data DW alone in the last beat
               tx_tdata = {32'b0, rc_data[63:32]};
               tx_tlast = 1'b1;
               tx_1dw   = 1'b1;
            end
         end
         TX_WR_HDR:
         begin
            if (word_cnt == '0)
               tx_tdata = {wr_dw1, wr_dw0};
            else
               tx_tdata = {wr_addr_q[31:0], wr_addr_q[63:32]};
         end
         TX_WR_DATA:
         begin
            tx_tdata = burst_data;
            tx_tlast = word_cnt == CW'(BW - 1);
         end
         default: tx_tdata = '0;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (wr_ready)
         wr_addr_q <= wr_addr;
   end

   always_ff @(posedge clock)
   begin
      if (rst)
      begin
         state       <= TX_IDLE;
         word_cnt    <= '0;
         cpl_pending <= 1'b0;
      end
      else
      begin
         case (state)
            TX_IDLE:
            begin
               if (cpl_pending)
                  state <= TX_CPL_HDR;
               else if (wr_valid)
                  state <= TX_WR_HDR;
            end
            TX_CPL_HDR:
            begin
               if (tx_tready)
                  state <= TX_CPL_DATA;
            end
            TX_CPL_DATA:
            begin
               if (tx_tready)
               begin
                  word_cnt <= tx_tlast ? '0 : word_cnt + 1'b1;
                  if (tx_tlast)
                  begin
                     state       <= TX_IDLE;
                     cpl_pending <= 1'b0;
                  end
               end
            end
            TX_WR_HDR:
            begin
               if (tx_tready)
               begin
                  word_cnt <= (word_cnt == '0) ? CW'(1) : '0;
                  if (word_cnt != '0)
                     state <= TX_WR_DATA;
               end
            end
            TX_WR_DATA:
            begin
               if (tx_tready)
               begin
                  word_cnt <= tx_tlast ? '0 : word_cnt + 1'b1;
                  if (tx_tlast)
                     state <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
         if (rc_done)
            cpl_pending <= 1'b1;
      end
   end

   // only one host read in flight
   a_cpl_not_lost: assert property (@(posedge clock) disable iff (rst)
      rc_done |-> !cpl_pending);

   a_stall_hold: assert property (@(posedge clock) disable iff (rst)
      tx_tvalid && !tx_tready |=>
         tx_tvalid && $stable(tx_tdata) && $stable(tx_tlast) && $stable(tx_1dw));

endmodule

// File: verif/hififo_pcie_tb.sv
`include "hififo_settings.svh"

module hififo_pcie_tb
   import pcie_tlp_pkg::*;
   import hififo_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 100;
   localparam pcie_id_t PCIE_ID = 16'h0300;
   localparam pcie_id_t REQ_ID = 16'h0100;
   // 7 PIO writes, 5 reads, 160 pushed words, 10 write TLPs
   localparam int TEST_BEATS = 7 * 3 + 5 * (2 + 3) + 160 + 10 * 18;

   // {tx_1dw, tx_tlast, tx_tdata}
   typedef logic [65:0] beat_rec_t;

   logic       clock;
   logic       rst;
   pcie_id_t   pcie_id;
   logic       rx_tvalid;
   logic       rx_tlast;
   tlp_beat_t  rx_tdata;
   logic       tx_tready;
   logic       tx_tvalid;
   tlp_beat_t  tx_tdata;
   logic       tx_tlast;
   logic       tx_1dw;
   logic       interrupt;
   logic       fifo_write;
   data_word_t fifo_data;
   logic       fifo_ready;

   int errors;
   int checks;
   logic stall_on;

   beat_rec_t exp_cpl[$];
   beat_rec_t exp_wr[$];
   beat_rec_t got[$];

   // host side view of the DUT state
   data_word_t model_words[$];
   dma_addr_t  model_base;
   dma_addr_t  ring_off;
   logic       model_enabled;
   logic       model_irq;
   int         bursts_planned;
   tlp_tag_t   next_tag;

   hififo_pcie UUT
   (
      .clock      (clock),
      .rst        (rst),
      .pcie_id    (pcie_id),
      .rx_tvalid  (rx_tvalid),
      .rx_tlast   (rx_tlast),
      .rx_tdata   (rx_tdata),
      .tx_tready  (tx_tready),
      .tx_tvalid  (tx_tvalid),
      .tx_tdata   (tx_tdata),
      .tx_tlast   (tx_tlast),
      .tx_1dw     (tx_1dw),
      .interrupt  (interrupt),
      .fifo_write (fifo_write),
      .fifo_data  (fifo_data),
      .fifo_ready (fifo_ready)
   );

   initial
   begin
      clock = 1'b0;
      forever
         #(CLK_PERIOD / 2) clock = ~clock;
   end

   // random core back-pressure while stall_on is set
   initial
   begin
      tx_tready = 1'b1;
      forever
      begin
         @(posedge clock);
         #5;
         tx_tready = stall_on ? ($urandom % 4 != 0) : 1'b1;
      end
   end

   // beats are taken on the edge after this sample
   initial
   begin
      forever
      begin
         @(negedge clock);
         if (!rst && tx_tvalid && tx_tready)
            got.push_back({tx_1dw, tx_tlast, tx_tdata});
      end
   end

   function automatic void expect_cpl(input tlp_tag_t tag, input tlp_dw_t byte_addr,
                                      input data_word_t value);
      tlp_dw_t dw0;
      tlp_dw_t dw1;
      tlp_dw_t dw2;
      dw0 = {1'b0, CPLD, 14'b0, tlp_len_t'(2)};
      // completer id, status 0, byte count 8
      dw1 = {PCIE_ID, 4'h0, 12'd8};
      dw2 = {REQ_ID, tag, 1'b0, byte_addr[6:0]};
      exp_cpl.push_back({2'b00, dw1, dw0});
      exp_cpl.push_back({2'b00, value[31:0], dw2});
      exp_cpl.push_back({2'b11, 32'h0, value[63:32]});
   endfunction

   function automatic void expect_write(input dma_addr_t addr);
      tlp_dw_t dw0;
      tlp_dw_t dw1;
      dw0 = {1'b0, MWR64, 14'b0, tlp_len_t'(2 * `HIFIFO_BURST_WORDS)};
      dw1 = {PCIE_ID, 8'h00, 4'hF, 4'hF};
      exp_wr.push_back({2'b00, dw1, dw0});
      // address high in DW2, low in DW3
      exp_wr.push_back({2'b00, addr[31:0], addr[63:32]});
      for (int i = 0; i < `HIFIFO_BURST_WORDS; i++)
         exp_wr.push_back({1'b0, i == `HIFIFO_BURST_WORDS - 1, model_words.pop_front()});
   endfunction

   // every full burst of the model leaves as one write TLP
   function automatic void plan_bursts();
      while (model_enabled && model_words.size() >= `HIFIFO_BURST_WORDS)
      begin
         expect_write(model_base + ring_off);
         ring_off = (ring_off + 2 * 4 * `HIFIFO_BURST_WORDS) % `HIFIFO_RING_BYTES;
         bursts_planned++;
      end
   endfunction

   function automatic data_word_t pio_read_value(input pio_addr_t addr);
      case (addr)
         pio_addr_t'(0): return data_word_t'(`HIFIFO_VERSION);
         pio_addr_t'(1): return model_base;
         pio_addr_t'(3): return data_word_t'(bursts_planned);
         default:        return '0;
      endcase
   endfunction

   task automatic check_level(input string name, input logic expected, input logic actual);
      checks++;
      assert (actual === expected)
      else
      begin
         errors++;
         $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
      end
   endtask

   task automatic check_beat(input beat_rec_t actual, input beat_rec_t expected);
      checks++;
      assert (actual[63:0] === expected[63:0])
      else
      begin
         errors++;
         $display("[ERROR] tx_tdata: expected %h, got %h", expected[63:0], actual[63:0]);
      end
      check_level("tx_tlast", expected[64], actual[64]);
      check_level("tx_1dw", expected[65], actual[65]);
   endtask

   task automatic send_tlp(input tlp_beat_t b0, input tlp_beat_t b1, input tlp_beat_t b2,
                           input int n);
      tlp_beat_t beats [3];
      beats[0] = b0;
      beats[1] = b1;
      beats[2] = b2;
      for (int i = 0; i < n; i++)
      begin
         @(posedge clock);
         #5;
         rx_tvalid = 1'b1;
         rx_tlast  = i == n - 1;
         rx_tdata  = beats[i];
      end
      @(posedge clock);
      #5;
      rx_tvalid = 1'b0;
      rx_tlast  = 1'b0;
      rx_tdata  = '0;
   endtask

   task automatic write_reg(input pio_addr_t addr, input data_word_t value);
      tlp_dw_t dw0;
      tlp_dw_t dw1;
      tlp_dw_t dw2;
      dw0 = {1'b0, MWR32, 14'b0, tlp_len_t'(2)};
      dw1 = {REQ_ID, next_tag, 8'hFF};
      dw2 = {16'h0000, addr, 3'b000};
      next_tag++;
      if (addr == pio_addr_t'(1))
      begin
         model_base = value;
         ring_off   = '0;
      end
      if (addr == pio_addr_t'(2))
      begin
         model_enabled = value[0];
         plan_bursts();
      end
      send_tlp({dw1, dw0}, {value[31:0], dw2}, {32'h0, value[63:32]}, 3);
   endtask

   task automatic wait_drained();
      while (exp_cpl.size() != 0 || exp_wr.size() != 0)
         @(posedge clock);
      repeat (4) @(posedge clock);
      #5;
   endtask

   // returns once the completion of this read has been checked
   task automatic read_reg(input pio_addr_t addr);
      tlp_dw_t dw0;
      tlp_dw_t dw1;
      tlp_dw_t dw2;
      dw0 = {1'b0, MRD32, 14'b0, tlp_len_t'(2)};
      dw1 = {REQ_ID, next_tag, 8'hFF};
      dw2 = {16'h0000, addr, 3'b000};
      expect_cpl(next_tag, dw2, pio_read_value(addr));
      next_tag++;
      send_tlp({dw1, dw0}, {32'h0, dw2}, '0, 2);
      wait_drained();
   endtask

   task automatic push_words(input int n);
      data_word_t word;
      int sent;
      sent = 0;
      while (sent < n)
      begin
         @(posedge clock);
         #5;
         if (fifo_ready)
         begin
            word       = {$urandom, $urandom};
            fifo_write = 1'b1;
            fifo_data  = word;
            model_words.push_back(word);
            sent++;
            plan_bursts();
         end
         else
            fifo_write = 1'b0;
      end
      @(posedge clock);
      #5;
      fifo_write = 1'b0;
   endtask

   task automatic set_interrupt(input logic level);
      write_reg(pio_addr_t'(0), data_word_t'(level));
      // one cycle after the last beat the old level still shows
      check_level("interrupt", model_irq, interrupt);
      @(posedge clock);
      #5;
      check_level("interrupt", level, interrupt);
      model_irq = level;
   endtask

   task automatic report_missing();
      if (exp_cpl.size() != 0)
      begin
         errors++;
         $display("missing completion, %0d expected beats never arrived", exp_cpl.size());
      end
      if (exp_wr.size() != 0)
      begin
         errors++;
         $display("missing write TLP, %0d expected beats never arrived", exp_wr.size());
      end
   endtask

   initial
   begin : compare
      beat_rec_t g;
      beat_rec_t e;
      logic in_tlp;
      logic is_cpl;
      logic stray;
      in_tlp = 1'b0;
      is_cpl = 1'b0;
      stray  = 1'b0;
      forever
      begin
         @(posedge clock);
         while (got.size() > 0)
         begin
            g = got.pop_front();
            if (!in_tlp)
            begin
               // header decides which expected stream it belongs to
               is_cpl = g[30:24] == CPLD;
               stray  = is_cpl ? exp_cpl.size() == 0 : exp_wr.size() == 0;
               if (stray)
               begin
                  errors++;
                  $display("extra TLP on the transmit stream, first beat %h", g[63:0]);
               end
            end
            else if (!stray && (is_cpl ? exp_cpl.size() == 0 : exp_wr.size() == 0))
            begin
               errors++;
               $display("transmitted TLP is longer than expected");
               stray = 1'b1;
            end
            if (!stray)
            begin
               if (is_cpl)
                  e = exp_cpl.pop_front();
               else
                  e = exp_wr.pop_front();
               check_beat(g, e);
            end
            in_tlp = !g[64];
         end
      end
   end

   initial
   begin
      #(TEST_BEATS * 40 * CLK_PERIOD);
      $display("timeout, the transmit stream stopped before all tests finished");
      report_missing();
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("Simulation FAILED");
      $finish;
   end

   initial
   begin
      void'($urandom(32'h2c6));
      errors         = 0;
      checks         = 0;
      stall_on       = 1'b0;
      model_base     = '0;
      ring_off       = '0;
      model_enabled  = 1'b0;
      model_irq      = 1'b0;
      bursts_planned = 0;
      next_tag       = '0;
      rst            = 1'b1;
      pcie_id        = PCIE_ID;
      rx_tvalid      = 1'b0;
      rx_tlast       = 1'b0;
      rx_tdata       = '0;
      fifo_write     = 1'b0;
      fifo_data      = '0;
      repeat (10) @(posedge clock);
      #5;
      rst = 1'b0;
      check_level("tx_tvalid", 1'b0, tx_tvalid);
      check_level("interrupt", 1'b0, interrupt);
      check_level("fifo_ready", 1'b1, fifo_ready);

      set_interrupt(1'b1);
      set_interrupt(1'b0);

      // register reads and bursts under random back-pressure
      stall_on = 1'b1;
      write_reg(pio_addr_t'(1), 64'h0000_0012_3450_0000);
      read_reg(pio_addr_t'(0));
      read_reg(pio_addr_t'(1));
      read_reg(pio_addr_t'(3));
      write_reg(pio_addr_t'(2), 64'h1);
      push_words(48);
      wait_drained();
      stall_on = 1'b0;

      // disabled buffer fills up and holds its data
      write_reg(pio_addr_t'(2), 64'h0);
      push_words(64);
      check_level("fifo_ready", 1'b0, fifo_ready);
      repeat (40) @(posedge clock);
      #5;
      check_level("tx_tvalid", 1'b0, tx_tvalid);
      write_reg(pio_addr_t'(2), 64'h1);
      wait_drained();
      check_level("fifo_ready", 1'b1, fifo_ready);

      // eighth burst ends the ring and the ninth is back at base
      push_words(32);
      wait_drained();
      write_reg(pio_addr_t'(1), 64'h0000_00AB_CDE0_0400);
      push_words(16);
      wait_drained();
      read_reg(pio_addr_t'(3));
      read_reg(pio_addr_t'(1));

      report_missing();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule
